/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --assert -Wno-fatal -j 0
TOP = core_tb
FILELIST = filelist.f
BUILD_DIR = obj_dir
SIM = $(BUILD_DIR)/V$(TOP)
SIM_ARGS = +verilator+error+limit+1000
LOG = sim.log
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(SIM_ARGS) | tee $(LOG)
	grep -qx 'NO ERRORS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
src/core_pkg.sv
src/fetch.sv
src/regfile.sv
src/decode.sv
src/execute.sv
src/memory.sv
src/core.sv
tb/tb_clock.sv
tb/core_checker.sv
tb/core_tb.sv

/* src/core.sv */
`timescale 1ns/100ps

module core (
	input  logic                clk,
	input  logic                reset,
	output logic                ireq_valid,
	output core_pkg::word_t     ireq_addr,
	input  logic                iresp_data_ok,
	input  core_pkg::instr_t    iresp_data,
	output logic                dreq_valid,
	output logic                dreq_write,
	output core_pkg::word_t     dreq_addr,
	output core_pkg::word_t     dreq_wdata,
	input  logic                dresp_data_ok,
	input  core_pkg::word_t     dresp_rdata,
	output logic                commit_valid,
	output core_pkg::word_t     commit_pc,
	output core_pkg::instr_t    commit_instr,
	output logic                commit_wen,
	output core_pkg::reg_addr_t commit_dst,
	output core_pkg::word_t     commit_data
);
	core_pkg::fetch_data_t f_reg;
	core_pkg::fetch_data_t fetch_out;
	core_pkg::decode_data_t d_reg;
	core_pkg::decode_data_t decode_out;
	core_pkg::execute_data_t e_reg;
	core_pkg::execute_data_t execute_out;
	core_pkg::memory_data_t m_reg;
	core_pkg::memory_data_t memory_out;

	logic stall_if;
	logic stall_mem;
	logic stall_bus;
	logic load_use;
	logic wb_wen;

	assign stall_if = ireq_valid & ~iresp_data_ok;
	assign stall_bus = stall_if | stall_mem;

	// Load in execute feeding the instruction in decode
	assign load_use = d_reg.valid & d_reg.ctl.mem_read & (d_reg.dst != 5'd0) &
		decode_out.valid & (d_reg.dst == decode_out.ra1 | d_reg.dst == decode_out.ra2);

	assign wb_wen = m_reg.valid & m_reg.reg_write & (m_reg.dst != 5'd0);

	fetch u_fetch (
		.clk          (clk),
		.reset        (reset),
		.stall        (stall_bus | load_use),
		.ireq_valid   (ireq_valid),
		.ireq_addr    (ireq_addr),
		.iresp_data_ok(iresp_data_ok),
		.iresp_data   (iresp_data),
		.fetch_out    (fetch_out)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			f_reg <= '0;
		end else if (!stall_bus && !load_use) begin
			f_reg <= fetch_out;
		end
	end

	decode u_decode (
		.clk       (clk),
		.reset     (reset),
		.fetch_in  (f_reg),
		.wen       (wb_wen),
		.wa        (m_reg.dst),
		.wd        (m_reg.wdata),
		.decode_out(decode_out)
	);

	// A held D entry picks up what retires meanwhile
	// since M turns into a bubble and its forward is gone
	always_ff @(posedge clk) begin
		if (reset) begin
			d_reg <= '0;
		end else if (stall_bus) begin
			if (wb_wen && m_reg.dst == d_reg.ra1) begin
				d_reg.rd1 <= m_reg.wdata;
			end
			if (wb_wen && m_reg.dst == d_reg.ra2) begin
				d_reg.rd2 <= m_reg.wdata;
			end
		end else if (load_use) begin
			d_reg <= '0;
		end else begin
			d_reg <= decode_out;
		end
	end

	execute u_execute (
		.decode_in  (d_reg),
		.exec_fwd   (e_reg),
		.mem_fwd    (m_reg),
		.execute_out(execute_out)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			e_reg <= '0;
		end else if (!stall_bus) begin
			e_reg <= execute_out;
		end
	end

	memory u_memory (
		.execute_in   (e_reg),
		.dreq_valid   (dreq_valid),
		.dreq_write   (dreq_write),
		.dreq_addr    (dreq_addr),
		.dreq_wdata   (dreq_wdata),
		.dresp_data_ok(dresp_data_ok),
		.dresp_rdata  (dresp_rdata),
		.stall_mem    (stall_mem),
		.memory_out   (memory_out)
	);

	always_ff @(posedge clk) begin
		if (reset || stall_bus) begin
			m_reg <= '0;
		end else begin
			m_reg <= memory_out;
		end
	end

	// Writeback point doubles as the commit trace
	assign commit_valid = m_reg.valid;
	assign commit_pc = m_reg.pc;
	assign commit_instr = m_reg.instr;
	assign commit_wen = wb_wen;
	assign commit_dst = m_reg.dst;
	assign commit_data = m_reg.wdata;

endmodule

/* src/core_pkg.sv */
package core_pkg;

	localparam int xlen = 64;
	localparam logic [63:0] reset_pc = 64'h8000_0000;

	typedef logic [4:0] reg_addr_t;
	typedef logic [xlen-1:0] word_t;
	typedef logic [31:0] instr_t;

	// Major opcodes of the supported subset
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor
	} alu_op_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic use_imm;
		logic mem_read;
		logic mem_write;
		logic reg_write;
	} ctl_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		instr_t instr;
	} fetch_data_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		instr_t instr;
		reg_addr_t ra1;
		reg_addr_t ra2;
		word_t rd1;
		word_t rd2;
		word_t imm;
		reg_addr_t dst;
		ctl_t ctl;
	} decode_data_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		instr_t instr;
		reg_addr_t dst;
		ctl_t ctl;
		word_t alu_result;
		word_t store_data;
	} execute_data_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		instr_t instr;
		reg_addr_t dst;
		logic reg_write;
		word_t wdata;
	} memory_data_t;

endpackage

/* src/decode.sv */
`timescale 1ns/100ps

module decode (
	input  logic                   clk,
	input  logic                   reset,
	input  core_pkg::fetch_data_t  fetch_in,
	input  logic                   wen,
	input  core_pkg::reg_addr_t    wa,
	input  core_pkg::word_t        wd,
	output core_pkg::decode_data_t decode_out
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	core_pkg::reg_addr_t rs1;
	core_pkg::reg_addr_t rs2;
	core_pkg::word_t imm_i;
	core_pkg::word_t imm_s;
	core_pkg::word_t rd1;
	core_pkg::word_t rd2;

	assign opcode = fetch_in.instr[6:0];
	assign funct3 = fetch_in.instr[14:12];
	assign funct7 = fetch_in.instr[31:25];
	assign rs1 = fetch_in.instr[19:15];
	assign rs2 = fetch_in.instr[24:20];
	assign imm_i = {{52{fetch_in.instr[31]}}, fetch_in.instr[31:20]};
	assign imm_s = {{52{fetch_in.instr[31]}}, fetch_in.instr[31:25], fetch_in.instr[11:7]};

	regfile u_regfile (
		.clk  (clk),
		.reset(reset),
		.ra1  (decode_out.ra1),
		.ra2  (decode_out.ra2),
		.rd1  (rd1),
		.rd2  (rd2),
		.wen  (wen),
		.wa   (wa),
		.wd   (wd)
	);

	always_comb begin
		decode_out = '0;
		decode_out.valid = fetch_in.valid;
		decode_out.pc = fetch_in.pc;
		decode_out.instr = fetch_in.instr;
		decode_out.ctl.alu_op = core_pkg::alu_add;
		// Unused sources stay at x0 so they never match a hazard
		unique case (opcode)
			core_pkg::op_reg: begin
				decode_out.ra1 = rs1;
				decode_out.ra2 = rs2;
				decode_out.dst = fetch_in.instr[11:7];
				decode_out.ctl.reg_write = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: decode_out.ctl.alu_op = core_pkg::alu_add;
					10'b0100000_000: decode_out.ctl.alu_op = core_pkg::alu_sub;
					10'b0000000_100: decode_out.ctl.alu_op = core_pkg::alu_xor;
					10'b0000000_110: decode_out.ctl.alu_op = core_pkg::alu_or;
					10'b0000000_111: decode_out.ctl.alu_op = core_pkg::alu_and;
					default: decode_out.ctl.reg_write = 1'b0;
				endcase
			end
			core_pkg::op_imm: begin
				decode_out.ra1 = rs1;
				decode_out.dst = fetch_in.instr[11:7];
				decode_out.imm = imm_i;
				decode_out.ctl.use_imm = 1'b1;
				decode_out.ctl.reg_write = (funct3 == 3'b000);
			end
			core_pkg::op_load: begin
				decode_out.ra1 = rs1;
				decode_out.dst = fetch_in.instr[11:7];
				decode_out.imm = imm_i;
				decode_out.ctl.use_imm = 1'b1;
				decode_out.ctl.mem_read = (funct3 == 3'b011);
				decode_out.ctl.reg_write = (funct3 == 3'b011);
			end
			core_pkg::op_store: begin
				decode_out.ra1 = rs1;
				decode_out.ra2 = rs2;
				decode_out.imm = imm_s;
				decode_out.ctl.use_imm = 1'b1;
				decode_out.ctl.mem_write = (funct3 == 3'b011);
			end
			// Anything else retires with no effect
			default: ;
		endcase
		decode_out.rd1 = rd1;
		decode_out.rd2 = rd2;
	end

endmodule

/* src/execute.sv */
`timescale 1ns/100ps

module execute (
	input  core_pkg::decode_data_t  decode_in,
	input  core_pkg::execute_data_t exec_fwd,
	input  core_pkg::memory_data_t  mem_fwd,
	output core_pkg::execute_data_t execute_out
);
	core_pkg::word_t src_a;
	core_pkg::word_t src_b;
	core_pkg::word_t op_b;

	// Youngest writer wins: E first, then M, then the register read
	function automatic core_pkg::word_t fwd_pick(
		input core_pkg::reg_addr_t     idx,
		input core_pkg::word_t         reg_val,
		input core_pkg::execute_data_t e,
		input core_pkg::memory_data_t  m
	);
		if (idx != 5'd0 && e.valid && e.ctl.reg_write && e.dst == idx) begin
			return e.alu_result;
		end else if (idx != 5'd0 && m.valid && m.reg_write && m.dst == idx) begin
			return m.wdata;
		end
		return reg_val;
	endfunction

	assign src_a = fwd_pick(decode_in.ra1, decode_in.rd1, exec_fwd, mem_fwd);
	assign src_b = fwd_pick(decode_in.ra2, decode_in.rd2, exec_fwd, mem_fwd);
	assign op_b = decode_in.ctl.use_imm ? decode_in.imm : src_b;

	always_comb begin
		execute_out.valid = decode_in.valid;
		execute_out.pc = decode_in.pc;
		execute_out.instr = decode_in.instr;
		execute_out.dst = decode_in.dst;
		execute_out.ctl = decode_in.ctl;
		execute_out.store_data = src_b;
		unique case (decode_in.ctl.alu_op)
			core_pkg::alu_sub: execute_out.alu_result = src_a - op_b;
			core_pkg::alu_and: execute_out.alu_result = src_a & op_b;
			core_pkg::alu_or:  execute_out.alu_result = src_a | op_b;
			core_pkg::alu_xor: execute_out.alu_result = src_a ^ op_b;
			default:           execute_out.alu_result = src_a + op_b;
		endcase
	end

endmodule

/* src/fetch.sv */
`timescale 1ns/100ps

module fetch (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	output logic                  ireq_valid,
	output core_pkg::word_t       ireq_addr,
	input  logic                  iresp_data_ok,
	input  core_pkg::instr_t      iresp_data,
	output core_pkg::fetch_data_t fetch_out
);
	core_pkg::word_t pc;

	// No branches, so the next pc is always pc + 4
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= core_pkg::reset_pc;
		end else if (!stall) begin
			pc <= pc + 64'd4;
		end
	end

	// Always requesting
	// a held pc keeps the address steady until data_ok
	assign ireq_valid = 1'b1;
	assign ireq_addr = pc;

	always_comb begin
		fetch_out.valid = iresp_data_ok;
		fetch_out.pc = pc;
		fetch_out.instr = iresp_data;
	end

endmodule

/* src/memory.sv */
`timescale 1ns/100ps

module memory (
	input  core_pkg::execute_data_t execute_in,
	output logic                    dreq_valid,
	output logic                    dreq_write,
	output core_pkg::word_t         dreq_addr,
	output core_pkg::word_t         dreq_wdata,
	input  logic                    dresp_data_ok,
	input  core_pkg::word_t         dresp_rdata,
	output logic                    stall_mem,
	output core_pkg::memory_data_t  memory_out
);
	logic mem_op;

	assign mem_op = execute_in.valid & (execute_in.ctl.mem_read | execute_in.ctl.mem_write);

	// Request fields come straight from the E register
	// which stays frozen while the bus waits
	assign dreq_valid = mem_op;
	assign dreq_write = execute_in.ctl.mem_write;
	assign dreq_addr = execute_in.alu_result;
	assign dreq_wdata = execute_in.store_data;

	assign stall_mem = mem_op & ~dresp_data_ok;

	always_comb begin
		memory_out.valid = execute_in.valid;
		memory_out.pc = execute_in.pc;
		memory_out.instr = execute_in.instr;
		memory_out.dst = execute_in.dst;
		memory_out.reg_write = execute_in.ctl.reg_write;
		if (execute_in.ctl.mem_read) begin
			memory_out.wdata = dresp_rdata;
		end else begin
			memory_out.wdata = execute_in.alu_result;
		end
	end

endmodule

/* src/regfile.sv */
`timescale 1ns/100ps

module regfile (
	input  logic                clk,
	input  logic                reset,
	input  core_pkg::reg_addr_t ra1,
	input  core_pkg::reg_addr_t ra2,
	output core_pkg::word_t     rd1,
	output core_pkg::word_t     rd2,
	input  logic                wen,
	input  core_pkg::reg_addr_t wa,
	input  core_pkg::word_t     wd
);
	core_pkg::word_t regs [31:1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rd1 = (ra1 == 5'd0) ? '0 : (wen && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : (wen && wa == ra2) ? wd : regs[ra2];

endmodule

/* tb/core_checker.sv */
`timescale 1ns/100ps

module core_checker (
	input logic                clk,
	input logic                reset,
	input logic                ireq_valid,
	input core_pkg::word_t     ireq_addr,
	input logic                iresp_data_ok,
	input logic                dreq_valid,
	input logic                dreq_write,
	input core_pkg::word_t     dreq_addr,
	input core_pkg::word_t     dreq_wdata,
	input logic                dresp_data_ok,
	input logic                commit_valid
);
	int fails = 0;

	ireq_held: assert property (@(posedge clk) disable iff (reset)
		ireq_valid && !iresp_data_ok |=> ireq_valid && $stable(ireq_addr))
	else begin
		fails++;
		$error("instruction request changed before data_ok");
	end

	dreq_held: assert property (@(posedge clk) disable iff (reset)
		dreq_valid && !dresp_data_ok |=> dreq_valid && $stable(dreq_write) &&
			$stable(dreq_addr) && $stable(dreq_wdata))
	else begin
		fails++;
		$error("data request changed before data_ok");
	end

	// Stage registers are cleared by the reset edge
	quiet_after_reset: assert property (@(posedge clk) reset |=> !commit_valid && !dreq_valid)
	else begin
		fails++;
		$error("commit or data request active right after a reset cycle");
	end

endmodule

/* tb/core_tb.sv */
`timescale 1ns/100ps

module core_tb;

	localparam int n_instr = 300;
	localparam int clk_period = 40;
	localparam int n_dwords = 256;

	logic clk;
	logic reset;
	logic ireq_valid;
	core_pkg::word_t ireq_addr;
	logic iresp_data_ok;
	core_pkg::instr_t iresp_data;
	logic dreq_valid;
	logic dreq_write;
	core_pkg::word_t dreq_addr;
	core_pkg::word_t dreq_wdata;
	logic dresp_data_ok;
	core_pkg::word_t dresp_rdata;
	logic commit_valid;
	core_pkg::word_t commit_pc;
	core_pkg::instr_t commit_instr;
	logic commit_wen;
	core_pkg::reg_addr_t commit_dst;
	core_pkg::word_t commit_data;

	core_pkg::instr_t prog [n_instr];
	core_pkg::word_t dmem [n_dwords];
	core_pkg::word_t model_mem [n_dwords];
	core_pkg::word_t model_regs [32];
	core_pkg::word_t model_pc;
	core_pkg::word_t last_waddr;
	core_pkg::word_t last_wdata;
	logic write_seen = 1'b0;
	int i_left = -1;
	int d_left = -1;
	int n_commits = 0;
	int errors = 0;
	int assert_fails;

	tb_clock #(.period(clk_period)) u_tb_clock (.clk(clk));

	core u_core (.*);

	bind core core_checker u_core_checker (
		.clk          (clk),
		.reset        (reset),
		.ireq_valid   (ireq_valid),
		.ireq_addr    (ireq_addr),
		.iresp_data_ok(iresp_data_ok),
		.dreq_valid   (dreq_valid),
		.dreq_write   (dreq_write),
		.dreq_addr    (dreq_addr),
		.dreq_wdata   (dreq_wdata),
		.dresp_data_ok(dresp_data_ok),
		.commit_valid (commit_valid)
	);

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s: expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	function automatic core_pkg::instr_t alu_instr(input logic [6:0] f7,
		input logic [2:0] f3, input core_pkg::reg_addr_t rd,
		input core_pkg::reg_addr_t rs1, input core_pkg::reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
	endfunction

	function automatic core_pkg::instr_t addi_instr(input core_pkg::reg_addr_t rd,
		input core_pkg::reg_addr_t rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, core_pkg::op_imm};
	endfunction

	// Loads and stores always use x0 as the base
	function automatic core_pkg::instr_t ld_instr(input core_pkg::reg_addr_t rd,
		input logic [11:0] off);
		return {off, 5'd0, 3'b011, rd, core_pkg::op_load};
	endfunction

	function automatic core_pkg::instr_t sd_instr(input core_pkg::reg_addr_t rs2,
		input logic [11:0] off);
		return {off[11:5], rs2, 5'd0, 3'b011, off[4:0], core_pkg::op_store};
	endfunction

	// Small register range keeps dependencies frequent
	function automatic core_pkg::reg_addr_t any_reg();
		return 5'($urandom_range(7, 0));
	endfunction

	function automatic logic [11:0] dword_offset();
		return 12'($urandom_range(n_dwords - 1, 0) * 8);
	endfunction

	function automatic core_pkg::instr_t mixed_alu(input core_pkg::reg_addr_t rd,
		input core_pkg::reg_addr_t rs1, input core_pkg::reg_addr_t rs2);
		case ($urandom_range(4, 0))
			0: return alu_instr(7'h00, 3'b000, rd, rs1, rs2);
			1: return alu_instr(7'h20, 3'b000, rd, rs1, rs2);
			2: return alu_instr(7'h00, 3'b100, rd, rs1, rs2);
			3: return alu_instr(7'h00, 3'b110, rd, rs1, rs2);
			default: return alu_instr(7'h00, 3'b111, rd, rs1, rs2);
		endcase
	endfunction

	function automatic core_pkg::instr_t random_instr();
		int kind;
		kind = $urandom_range(9, 0);
		if (kind < 4) begin
			return mixed_alu(any_reg(), any_reg(), any_reg());
		end else if (kind < 6) begin
			return addi_instr(any_reg(), any_reg(), 12'($urandom));
		end else if (kind < 8) begin
			return ld_instr(any_reg(), dword_offset());
		end
		return sd_instr(any_reg(), dword_offset());
	endfunction

	task automatic build_program();
		for (int i = 0; i < n_instr; i++) begin
			prog[i] = random_instr();
		end
		// Load, load-use, then chains through E and M forwarding
		for (int i = 20; i <= 40; i++) begin
			case ((i - 20) % 4)
				0: prog[i] = ld_instr(5'd5, dword_offset());
				1: prog[i] = mixed_alu(5'd6, 5'd5, any_reg());
				2: prog[i] = addi_instr(5'd7, 5'd6, 12'($urandom));
				default: prog[i] = mixed_alu(5'd5, 5'd7, 5'd6);
			endcase
		end
	endtask

	function automatic core_pkg::word_t fill_word(input int idx);
		return {32'hfeed_0000 ^ 32'(idx * 8), ~32'(idx * 8)};
	endfunction

	// Past the program the bus returns ADDI x0, x0, 0
	function automatic core_pkg::instr_t fetch_word(input core_pkg::word_t addr);
		core_pkg::word_t idx;
		idx = (addr - core_pkg::reset_pc) >> 2;
		if (addr >= core_pkg::reset_pc && idx < 64'(n_instr)) begin
			return prog[int'(idx)];
		end
		return 32'h0000_0013;
	endfunction

	task automatic compare_commit();
		core_pkg::instr_t ins;
		core_pkg::reg_addr_t rd;
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t imm_i;
		core_pkg::word_t imm_s;
		core_pkg::word_t res;
		core_pkg::word_t addr;
		logic wen;
		string tag;
		ins = fetch_word(model_pc);
		tag = $sformatf("commit %0d", n_commits);
		rd = ins[11:7];
		a = model_regs[ins[19:15]];
		b = model_regs[ins[24:20]];
		imm_i = {{52{ins[31]}}, ins[31:20]};
		imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
		res = '0;
		wen = 1'b0;
		check({tag, " pc"}, model_pc, commit_pc);
		check({tag, " instr"}, 64'(ins), 64'(commit_instr));
		case (ins[6:0])
			core_pkg::op_reg: begin
				wen = 1'b1;
				case (ins[14:12])
					3'b000: res = ins[30] ? a - b : a + b;
					3'b100: res = a ^ b;
					3'b110: res = a | b;
					default: res = a & b;
				endcase
			end
			core_pkg::op_imm: begin
				wen = 1'b1;
				res = a + imm_i;
			end
			core_pkg::op_load: begin
				wen = 1'b1;
				addr = a + imm_i;
				res = model_mem[addr[10:3]];
			end
			core_pkg::op_store: begin
				addr = a + imm_s;
				if (!write_seen) begin
					$display("Store at pc %h retired without a data bus write", model_pc);
					errors++;
				end
				check({tag, " store addr"}, addr, last_waddr);
				check({tag, " store data"}, b, last_wdata);
				write_seen = 1'b0;
				model_mem[addr[10:3]] = b;
			end
			default: ;
		endcase
		wen = wen && rd != 5'd0;
		check({tag, " wen"}, 64'(wen), 64'(commit_wen));
		if (wen) begin
			check({tag, " dst"}, 64'(rd), 64'(commit_dst));
			check({tag, " data"}, res, commit_data);
			model_regs[rd] = res;
		end
		model_pc = model_pc + 64'd4;
	endtask

	// Bus models, 0 to 3 wait cycles per request
	always @(negedge clk) begin
		if (reset) begin
			iresp_data_ok <= 1'b0;
			dresp_data_ok <= 1'b0;
			i_left = -1;
			d_left = -1;
		end else begin
			if (!ireq_valid) begin
				iresp_data_ok <= 1'b0;
				i_left = -1;
			end else begin
				if (i_left < 0) begin
					i_left = $urandom_range(3, 0);
				end
				if (i_left == 0) begin
					iresp_data_ok <= 1'b1;
					iresp_data <= fetch_word(ireq_addr);
					i_left = -1;
				end else begin
					iresp_data_ok <= 1'b0;
					i_left--;
				end
			end
			if (!dreq_valid) begin
				dresp_data_ok <= 1'b0;
				d_left = -1;
			end else begin
				if (d_left < 0) begin
					d_left = $urandom_range(3, 0);
				end
				if (d_left == 0) begin
					dresp_data_ok <= 1'b1;
					dresp_rdata <= dmem[dreq_addr[10:3]];
					d_left = -1;
				end else begin
					dresp_data_ok <= 1'b0;
					d_left--;
				end
			end
		end
	end

	// Commit is compared before this cycle's write is recorded
	always @(posedge clk) begin
		if (!reset) begin
			if (commit_valid) begin
				compare_commit();
				n_commits++;
			end
			if (dreq_valid && dreq_write && dresp_data_ok) begin
				if (dreq_addr >= 64'(n_dwords * 8) || dreq_addr[2:0] != 3'd0) begin
					$display("Data bus write to unexpected address %h", dreq_addr);
					errors++;
				end else begin
					dmem[dreq_addr[10:3]] = dreq_wdata;
				end
				last_waddr = dreq_addr;
				last_wdata = dreq_wdata;
				write_seen = 1'b1;
			end
		end
	end

	initial begin
		#(n_instr * 40 * clk_period);
		$display("Timeout with %0d of %0d instructions retired", n_commits, n_instr);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		reset = 1'b1;
		iresp_data_ok = 1'b0;
		iresp_data = '0;
		dresp_data_ok = 1'b0;
		dresp_rdata = '0;
		void'($urandom(32'he2502cb1));
		build_program();
		for (int i = 0; i < n_dwords; i++) begin
			dmem[i] = fill_word(i);
			model_mem[i] = fill_word(i);
		end
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		model_pc = core_pkg::reset_pc;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
		wait (n_commits >= n_instr);
		assert_fails = u_core.u_core_checker.fails;
		$display("Retired %0d instructions, %0d check errors, %0d assertion failures",
			n_commits, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
	parameter int period = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2) clk = ~clk;
		end
	end

endmodule
